// File: hw/alloc_pkg.sv
package alloc_pkg;

  // ------------------------------------------------------------
  // Allocator dimensions
  // ------------------------------------------------------------

  localparam int NUM_IN  = 4;  // Router input ports
  localparam int NUM_OUT = 4;  // Router output ports

  // ------------------------------------------------------------
  // Request and grant vectors
  // ------------------------------------------------------------

  typedef logic [NUM_IN-1:0]  in_vec_t;   // One bit per input
  typedef logic [NUM_OUT-1:0] out_vec_t;  // One bit per output

  // Row per input, column per output
  // Used for requests and input-side grants
  typedef out_vec_t [NUM_IN-1:0] req_matrix_t;

  // Row per output, column per input
  // Transpose of req_matrix_t, as seen by the output arbiters
  typedef in_vec_t [NUM_OUT-1:0] ogrant_matrix_t;

endpackage

// File: hw/flit_pkg.sv
package flit_pkg;

  localparam int QUEUE_DEPTH = 4;                       // Entries per input FIFO
  localparam int QPTR_W      = $clog2(QUEUE_DEPTH);     // FIFO pointer width
  localparam int QCNT_W      = $clog2(QUEUE_DEPTH + 1); // Occupancy, 0 to depth
  localparam int PORT_W      = 2;                       // Enough for 4 ports
  localparam int TAG_W       = 8;

  typedef logic [PORT_W-1:0] port_id_t;  // Input or output index
  typedef logic [TAG_W-1:0]  tag_t;      // Request tag

  // Queued request, 10 bits
  typedef struct packed {
    port_id_t dest;  // Requested output
    tag_t     tag;
  } req_entry_t;

  // Output port result, 11 bits
  typedef struct packed {
    logic     valid;  // Output granted this cycle
    port_id_t src;    // Winning input
    tag_t     tag;    // Tag of winning head entry
  } out_port_t;

endpackage

// File: hw/rr_arbiter.sv
`timescale 1ns/10ps

module rr_arbiter #(
  parameter int N = 4  // Number of requesters
) (
  input  logic         clk,
  input  logic         i_rst_n,
  input  logic         i_en,       // Allows pointer update
  input  logic [N-1:0] i_request,
  output logic [N-1:0] o_grant     // One-hot or zero
);

  logic [$clog2(N)-1:0] l_ptr;      // Highest priority index
  logic [$clog2(N)-1:0] l_win_idx;  // Index that won this cycle
  logic                 l_found;    // Any request seen

  // ------------------------------------------------------------
  // Priority search
  // ------------------------------------------------------------

  // Walk cyclically from the pointer, first requester wins
  always_comb begin
    int idx;
    o_grant   = '0;
    l_found   = 1'b0;
    l_win_idx = '0;
    for (int k = 0; k < N; k++) begin
      idx = (int'(l_ptr) + k) % N;
      if (!l_found && i_request[idx]) begin
        l_found      = 1'b1;
        l_win_idx    = idx[$clog2(N)-1:0];
        o_grant[idx] = 1'b1;
      end
    end
  end

  // ------------------------------------------------------------
  // Pointer update
  // ------------------------------------------------------------

  // Winner drops to lowest priority
  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      l_ptr <= '0;
    end else if (i_en && l_found) begin
      if (l_win_idx == ($clog2(N))'(N - 1)) begin
        l_ptr <= '0;                 // Wrap past last requester
      end else begin
        l_ptr <= l_win_idx + 1'b1;
      end
    end
  end

endmodule

// File: hw/islip_allocator.sv
`timescale 1ns/10ps

module islip_allocator (
  input  logic                      clk,
  input  logic                      i_rst_n,
  input  logic                      i_ce,       // Low forces idle, pointers hold
  input  alloc_pkg::req_matrix_t    i_request,  // Input by output
  output alloc_pkg::req_matrix_t    o_i_grant,  // Input by output
  output alloc_pkg::ogrant_matrix_t o_o_grant   // Output by input
);

  import alloc_pkg::*;

  req_matrix_t    l_req_masked;     // Requests gated by clock enable
  req_matrix_t    l_input_grant;    // Input stage choices
  ogrant_matrix_t l_intermediate;   // Choices seen per output
  in_vec_t        l_in_en;          // Input pointer update enables

  assign l_req_masked = i_ce ? i_request : '0;

  // ------------------------------------------------------------
  // Input stage, one arbiter per input
  // ------------------------------------------------------------

  for (genvar i = 0; i < NUM_IN; i++) begin : gen_in_arb
    rr_arbiter #(.N(NUM_OUT)) u_rr_in (
      .clk,
      .i_rst_n,
      .i_en      (l_in_en[i]),       // Only moves when accepted
      .i_request (l_req_masked[i]),
      .o_grant   (l_input_grant[i])
    );
  end

  // Transpose input choices for the output stage
  always_comb begin
    l_intermediate = '0;
    for (int j = 0; j < NUM_OUT; j++) begin
      for (int i = 0; i < NUM_IN; i++) begin
        l_intermediate[j][i] = l_input_grant[i][j];
      end
    end
  end

  // ------------------------------------------------------------
  // Output stage, one arbiter per output
  // ------------------------------------------------------------

  for (genvar j = 0; j < NUM_OUT; j++) begin : gen_out_arb
    rr_arbiter #(.N(NUM_IN)) u_rr_out (
      .clk,
      .i_rst_n,
      .i_en      (i_ce),               // Moves on every grant
      .i_request (l_intermediate[j]),
      .o_grant   (o_o_grant[j])
    );
  end

  // Output grants back to input orientation
  always_comb begin
    o_i_grant = '0;
    for (int i = 0; i < NUM_IN; i++) begin
      for (int j = 0; j < NUM_OUT; j++) begin
        o_i_grant[i][j] = o_o_grant[j][i];
      end
    end
  end

  // iSLIP rule, input pointer follows accepted grant only
  always_comb begin
    for (int i = 0; i < NUM_IN; i++) begin
      l_in_en[i] = |o_i_grant[i];
    end
  end

endmodule

// File: hw/input_req_queue.sv
`timescale 1ns/10ps

module input_req_queue (
  input  logic                 clk,
  input  logic                 i_rst_n,
  input  logic                 i_push,     // Write strobe
  input  flit_pkg::req_entry_t i_entry,
  input  alloc_pkg::out_vec_t  i_grant,    // Row of input grant matrix
  output logic                 o_full,
  output alloc_pkg::out_vec_t  o_request,  // One-hot head request
  output flit_pkg::req_entry_t o_head
);

  import flit_pkg::*;

  req_entry_t        l_mem [QUEUE_DEPTH];  // Entry storage
  logic [QPTR_W-1:0] l_wr_ptr;
  logic [QPTR_W-1:0] l_rd_ptr;
  logic [QCNT_W-1:0] l_count;              // Occupied entries
  logic              l_push;
  logic              l_pop;

  assign o_full = (l_count == QCNT_W'(QUEUE_DEPTH));
  assign l_push = i_push && !o_full;          // Push when full is dropped
  assign l_pop  = (|i_grant) && (l_count != '0);

  // ------------------------------------------------------------
  // Storage
  // ------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (l_push) begin
      l_mem[l_wr_ptr] <= i_entry;
    end
  end

  // ------------------------------------------------------------
  // Pointers and count
  // ------------------------------------------------------------

  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      l_wr_ptr <= '0;
      l_rd_ptr <= '0;
      l_count  <= '0;
    end else begin
      if (l_push) begin
        l_wr_ptr <= (l_wr_ptr == QPTR_W'(QUEUE_DEPTH - 1)) ? '0 : l_wr_ptr + 1'b1;
      end
      if (l_pop) begin
        l_rd_ptr <= (l_rd_ptr == QPTR_W'(QUEUE_DEPTH - 1)) ? '0 : l_rd_ptr + 1'b1;
      end
      // Both at once leaves count alone
      case ({l_push, l_pop})
        2'b10:   l_count <= l_count + 1'b1;
        2'b01:   l_count <= l_count - 1'b1;
        default: l_count <= l_count;
      endcase
    end
  end

  // Head entry and its request row
  assign o_head = l_mem[l_rd_ptr];

  always_comb begin
    o_request = '0;
    if (l_count != '0) begin
      o_request[o_head.dest] = 1'b1;  // Decode destination
    end
  end

endmodule

// File: hw/grant_crossbar.sv
`timescale 1ns/10ps

module grant_crossbar (
  input  alloc_pkg::ogrant_matrix_t                       i_o_grant,  // Output by input
  input  flit_pkg::req_entry_t [alloc_pkg::NUM_IN-1:0]    i_heads,    // Head of each queue
  output flit_pkg::out_port_t  [alloc_pkg::NUM_OUT-1:0]   o_out
);

  import alloc_pkg::*;
  import flit_pkg::*;

  // Per output, encode the one-hot column and pick the head tag
  always_comb begin
    port_id_t src;
    for (int j = 0; j < NUM_OUT; j++) begin
      src = '0;
      for (int i = 0; i < NUM_IN; i++) begin
        if (i_o_grant[j][i]) begin
          src = port_id_t'(i);  // At most one bit set
        end
      end
      o_out[j].valid = |i_o_grant[j];
      o_out[j].src   = src;
      o_out[j].tag   = i_heads[src].tag;
    end
  end

endmodule

// File: hw/switch_alloc_top.sv
`timescale 1ns/10ps

module switch_alloc_top (
  input  logic                                          clk,
  input  logic                                          i_rst_n,
  input  logic                                          i_ce,     // Allocation enable
  input  alloc_pkg::in_vec_t                            i_push,   // Per input push strobe
  input  flit_pkg::req_entry_t [alloc_pkg::NUM_IN-1:0]  i_entry,
  output alloc_pkg::in_vec_t                            o_full,
  output flit_pkg::out_port_t  [alloc_pkg::NUM_OUT-1:0] o_out
);

  import alloc_pkg::*;
  import flit_pkg::*;

  req_matrix_t                   l_request;  // Head requests of all queues
  req_matrix_t                   l_i_grant;  // Grants by input, pops queues
  ogrant_matrix_t                l_o_grant;  // Grants by output, drives crossbar
  req_entry_t [NUM_IN-1:0]       l_heads;

  // ------------------------------------------------------------
  // Request queues
  // ------------------------------------------------------------

  for (genvar i = 0; i < NUM_IN; i++) begin : gen_queue
    input_req_queue u_queue (
      .clk,
      .i_rst_n,
      .i_push    (i_push[i]),
      .i_entry   (i_entry[i]),
      .i_grant   (l_i_grant[i]),
      .o_full    (o_full[i]),
      .o_request (l_request[i]),
      .o_head    (l_heads[i])
    );
  end

  // Separable allocator
  islip_allocator u_alloc (
    .clk,
    .i_rst_n,
    .i_ce,
    .i_request (l_request),
    .o_i_grant (l_i_grant),
    .o_o_grant (l_o_grant)
  );

  grant_crossbar u_xbar (
    .i_o_grant (l_o_grant),
    .i_heads   (l_heads),
    .o_out     (o_out)       // Same cycle as the requests
  );

endmodule

// File: tests/switch_alloc_assert.sv
`timescale 1ns/10ps

module switch_alloc_assert (
  input logic                                          clk,
  input logic                                          i_rst_n,
  input logic                                          i_ce,
  input alloc_pkg::in_vec_t                            i_full,     // DUT o_full
  input flit_pkg::out_port_t  [alloc_pkg::NUM_OUT-1:0] i_out,      // DUT o_out
  input alloc_pkg::req_matrix_t                        i_request   // Head requests
);

  import alloc_pkg::*;
  import flit_pkg::*;

  int unsigned fail_cnt = 0;  // Read by the testbench at the end
  out_vec_t    valid_bits;
  in_vec_t     row_any;       // Inputs with a nonempty queue
  out_vec_t    lone_dest;     // OR of all request rows
  logic        dup_src;       // One input on two outputs
  logic        bad_route;     // Grant without matching request
  logic        all_want0;     // Every head targets output 0
  port_id_t    last_src0;     // Last winner of output 0
  port_id_t    next_src0;

  always_comb begin
    valid_bits = '0;
    row_any    = '0;
    lone_dest  = '0;
    dup_src    = 1'b0;
    bad_route  = 1'b0;
    all_want0  = 1'b1;
    for (int j = 0; j < NUM_OUT; j++) begin
      valid_bits[j] = i_out[j].valid;
      if (i_out[j].valid && !i_request[i_out[j].src][j]) bad_route = 1'b1;
      for (int k = j + 1; k < NUM_OUT; k++) begin
        if (i_out[j].valid && i_out[k].valid && i_out[j].src == i_out[k].src) dup_src = 1'b1;
      end
    end
    for (int i = 0; i < NUM_IN; i++) begin
      row_any[i] = |i_request[i];
      lone_dest  = lone_dest | i_request[i];
      all_want0  = all_want0 & i_request[i][0];
    end
    // Output pointer sits one past the last winner
    next_src0 = (last_src0 == port_id_t'(NUM_IN - 1)) ? '0 : last_src0 + 1'b1;
  end

  // Reset value makes input 0 the first expected winner
  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      last_src0 <= port_id_t'(NUM_IN - 1);
    end else if (i_out[0].valid) begin
      last_src0 <= i_out[0].src;
    end
  end

  // ------------------------------------------------------------
  // Properties
  // ------------------------------------------------------------

  a_reset_idle: assert property (@(posedge clk)
    $rose(i_rst_n) |-> (valid_bits == '0 && i_full == '0))
    else begin $error("Outputs or full flags active right after reset"); fail_cnt++; end

  a_unique_src: assert property (@(posedge clk) disable iff (!i_rst_n) !dup_src)
    else begin $error("One input granted on two outputs"); fail_cnt++; end

  a_route: assert property (@(posedge clk) disable iff (!i_rst_n) !bad_route)
    else begin $error("Output valid without a matching head request"); fail_cnt++; end

  a_ce_idle: assert property (@(posedge clk) disable iff (!i_rst_n)
    !i_ce |-> valid_bits == '0)
    else begin $error("Grant issued while clock enable is low"); fail_cnt++; end

  a_fair: assert property (@(posedge clk) disable iff (!i_rst_n)
    (i_ce && all_want0) |-> (i_out[0].valid && i_out[0].src == next_src0))
    else begin $error("Output 0 winner breaks round-robin order"); fail_cnt++; end

  a_lone: assert property (@(posedge clk) disable iff (!i_rst_n)
    (i_ce && $onehot(row_any)) |-> ((valid_bits & lone_dest) == lone_dest))
    else begin $error("Lone request not granted"); fail_cnt++; end

endmodule

// File: tests/tb_switch_alloc.sv
`timescale 1ns/10ps

module tb_switch_alloc;

  import alloc_pkg::*;
  import flit_pkg::*;

  localparam int CLK_PERIOD = 100;
  localparam int DRIVE_DLY  = 10;   // Input skew after rising edge
  localparam int RESET_CYC  = 5;
  localparam int IDLE_CYC   = 4;
  localparam int PHASE_CYC  = 150;
  localparam int NUM_PHASES = 4;
  localparam int DRAIN_CYC  = 40;   // Worst case to empty 16 entries, with slack
  localparam int MARGIN_CYC = 50;
  localparam int RUN_CYC    = RESET_CYC + IDLE_CYC
                              + NUM_PHASES * (PHASE_CYC + DRAIN_CYC) + MARGIN_CYC;

  logic                    clk = 1'b0;
  logic                    i_rst_n;
  logic                    i_ce;
  in_vec_t                 i_push;
  req_entry_t [NUM_IN-1:0] i_entry;
  in_vec_t                 o_full;
  out_port_t [NUM_OUT-1:0] o_out;

  req_entry_t  model_q [NUM_IN][$];  // Expected entries per input
  logic [5:0]  tag_cnt [NUM_IN];
  logic [31:0] lfsr   = 32'h79f;
  int          errors = 0;
  int          checks = 0;
  int          tests  = 0;

  switch_alloc_top i_dut (.clk, .i_rst_n, .i_ce, .i_push, .i_entry, .o_full, .o_out);

  bind switch_alloc_top switch_alloc_assert u_chk (
    .clk       (clk),
    .i_rst_n   (i_rst_n),
    .i_ce      (i_ce),
    .i_full    (o_full),
    .i_out     (o_out),
    .i_request (l_request)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  // ------------------------------------------------------------
  // Stimulus helpers
  // ------------------------------------------------------------

  // Galois LFSR, one step per bit
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int b = 0; b < n; b++) begin
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
      r[b] = lfsr[0];
    end
    return r;
  endfunction

  function automatic int pending();
    int n;
    n = 0;
    for (int i = 0; i < NUM_IN; i++) n += model_q[i].size();
    return n;
  endfunction

  task automatic drive_cycle(input in_vec_t src_mask, input logic to_zero, input logic ce_gaps);
    req_entry_t e;
    @(posedge clk);
    #(DRIVE_DLY);
    for (int i = 0; i < NUM_IN; i++) begin
      i_push[i] = 1'b0;
      if (src_mask[i] && !o_full[i] && (to_zero || take_bits(1) != 0)) begin
        e.dest     = to_zero ? port_id_t'(0) : port_id_t'(take_bits(2));
        e.tag      = {port_id_t'(i), tag_cnt[i]};  // Input index on top
        tag_cnt[i] = tag_cnt[i] + 1'b1;
        i_entry[i] = e;
        i_push[i]  = 1'b1;
        model_q[i].push_back(e);
      end
    end
    i_ce = ce_gaps ? (take_bits(2) != 0) : 1'b1;  // Low about one cycle in four
  endtask

  // Stop pushing, wait until the model runs dry or the drain budget is spent
  task automatic drain();
    int wait_cyc;
    wait_cyc = 0;
    @(posedge clk);
    #(DRIVE_DLY);
    i_push = '0;
    i_ce   = 1'b1;
    while (pending() != 0 && wait_cyc < DRAIN_CYC) begin
      @(posedge clk);
      wait_cyc++;
    end
    @(posedge clk);
  endtask

  task automatic report_test(input string name);
    tests++;
    $display("test %-16s done at %0t, errors so far %0d", name, $time,
             errors + int'(i_dut.u_chk.fail_cnt));
  endtask

  // ------------------------------------------------------------
  // Scoreboard, sampled mid-cycle
  // ------------------------------------------------------------

  task automatic check_outputs();
    req_entry_t exp;
    port_id_t   s;
    int         held;
    // Queue fill before this cycle's pops, minus a push not yet written
    for (int i = 0; i < NUM_IN; i++) begin
      held = model_q[i].size() - int'(i_push[i]);
      assert (o_full[i] == (held == QUEUE_DEPTH)) else begin
        $display("mismatch at %0t: o_full[%0d] expected %b actual %b",
                 $time, i, held == QUEUE_DEPTH, o_full[i]);
        errors++;
      end
    end
    for (int j = 0; j < NUM_OUT; j++) begin
      if (o_out[j].valid) begin
        s = o_out[j].src;
        checks++;
        assert (model_q[s].size() != 0) else begin
          $display("At %0t output %0d granted input %0d with nothing queued", $time, j, s);
          errors++;
        end
        if (model_q[s].size() != 0) begin
          exp = model_q[s].pop_front();
          assert (exp.tag == o_out[j].tag) else begin
            $display("mismatch at %0t: o_out[%0d].tag expected %h actual %h",
                     $time, j, exp.tag, o_out[j].tag);
            errors++;
          end
          assert (exp.dest == port_id_t'(j)) else begin
            $display("mismatch at %0t: dest of o_out[%0d] expected %0d actual %0d",
                     $time, j, exp.dest, j);
            errors++;
          end
        end
      end
    end
  endtask

  always @(negedge clk) begin
    if (i_rst_n) check_outputs();
  end

  // ------------------------------------------------------------
  // Test sequence
  // ------------------------------------------------------------

  initial begin
    i_rst_n = 1'b0;
    i_ce    = 1'b0;
    i_push  = '0;
    i_entry = '0;
    for (int i = 0; i < NUM_IN; i++) tag_cnt[i] = '0;
    repeat (RESET_CYC) @(posedge clk);
    #(DRIVE_DLY);
    i_rst_n = 1'b1;
    i_ce    = 1'b1;
    repeat (IDLE_CYC) @(posedge clk);
    report_test("reset state");
    repeat (PHASE_CYC) drive_cycle(4'b1111, 1'b0, 1'b0);
    drain();
    report_test("random traffic");
    repeat (PHASE_CYC) drive_cycle(4'b1111, 1'b0, 1'b1);
    drain();
    report_test("clock enable");
    repeat (PHASE_CYC) drive_cycle(4'b1111, 1'b1, 1'b0);  // All heads on output 0
    drain();
    report_test("fairness");
    repeat (PHASE_CYC) drive_cycle(4'b0100, 1'b0, 1'b1);  // Input 2 alone
    drain();
    report_test("lone request");
    for (int i = 0; i < NUM_IN; i++) begin
      assert (model_q[i].size() == 0) else begin
        $display("Input %0d still has %0d tags never granted", i, model_q[i].size());
        errors++;
      end
    end
    $display("tests %0d, grant checks %0d, scoreboard errors %0d, assertion failures %0d",
             tests, checks, errors, i_dut.u_chk.fail_cnt);
    if (errors == 0 && i_dut.u_chk.fail_cnt == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #(RUN_CYC * CLK_PERIOD);
    $display("Timeout after %0d cycles, test sequence did not finish", RUN_CYC);
    $display("Simulation failed");
    $finish;
  end

endmodule

// File: compile.f
hw/alloc_pkg.sv
hw/flit_pkg.sv
hw/rr_arbiter.sv
hw/islip_allocator.sv
hw/input_req_queue.sv
hw/grant_crossbar.sv
hw/switch_alloc_top.sv
tests/switch_alloc_assert.sv
tests/tb_switch_alloc.sv

// File: Bender.yml
package:
  name: switch_alloc

sources:
  - files:
      - hw/alloc_pkg.sv
      - hw/flit_pkg.sv
      - hw/rr_arbiter.sv
      - hw/islip_allocator.sv
      - hw/input_req_queue.sv
      - hw/grant_crossbar.sv
      - hw/switch_alloc_top.sv
  - target: test
    files:
      - tests/switch_alloc_assert.sv
      - tests/tb_switch_alloc.sv
